//--- compile.f
source/mem_store_pkg.sv
source/store_align.sv
source/store_buffer_ctrl.sv
source/store_buffer_ram.sv
source/dmem_write_fsm.sv
source/mem_store_stage.sv
sim/tb_mem_store_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the store stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
      --timescale 1ns/100ps \
      --top-module tb_mem_store_stage \
      --Mdir obj_dir \
      -f compile.f; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_mem_store_stage)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
   exit 0
fi
exit 1

//--- sim/tb_mem_store_stage.sv
`timescale 1ns/100ps

module tb_mem_store_stage
   import mem_store_pkg::*;
();

   localparam int SB_BITS    = 3;
   localparam int SB_CAP     = 2**SB_BITS - 1;
   localparam int CLK_PERIOD = 10;
   localparam int N_RANDOM   = 200;
   localparam int N_STORES   = 15 + 10 + N_RANDOM;

   logic        clock = 1'b0;
   logic        arst_n;
   logic        store_valid;
   store_req_t  store;
   logic        dmem_waitrequest;
   dmem_wr_t    dmem;
   logic        restart;
   logic [31:0] restart_pc;
   logic [31:0] perf_sb_full;

   // Reference model, expected writes in arrival order
   sb_entry_t   exp_mem [256];
   sb_entry_t   exp_head;
   logic [7:0]  exp_head_idx;
   logic [7:0]  exp_tail_idx;
   int          buf_cnt;
   logic        exp_holding;
   logic        exp_restart;
   logic [31:0] exp_restart_pc;
   logic [31:0] exp_perf;
   logic [31:0] n_strobes;
   logic [31:0] n_writes;
   logic        arst_q = 1'b0;
   logic [31:0] rng_state;
   logic        random_wait;
   int          check_errors;
   int          other_errors;
   logic        full_now;
   logic        push_now;
   logic        take_now;
   logic        pop_now;
   logic        exp_accept;

   always #(CLK_PERIOD / 2) clock = ~clock;

   mem_store_stage #(
      .SB_BITS (SB_BITS)
   ) mem_store_stage_inst (
      .clock            (clock),
      .arst_n           (arst_n),
      .store_valid      (store_valid),
      .store            (store),
      .dmem_waitrequest (dmem_waitrequest),
      .dmem             (dmem),
      .restart          (restart),
      .restart_pc       (restart_pc),
      .perf_sb_full     (perf_sb_full)
   );

   // ------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------
   function automatic sb_entry_t expected_entry(input store_req_t s);
      sb_entry_t   e;
      logic [1:0]  off;
      logic [1:0]  rot;
      logic [63:0] twice;
      int          lane;
      off = s.address[1:0];
      case (s.opcode)
         OP_SH:         rot = off + 2'd2;
         OP_SB, OP_SWR: rot = off + 2'd1;
         default:       rot = off;
      endcase
      // Right rotation by whole bytes through a doubled word
      twice       = {s.rt_val, s.rt_val} >> (8 * rot);
      e.data      = twice[31:0];
      e.word_addr = s.address[31:2];
      // Lane 0 is the MSB and maps to byteena bit 3
      for (lane = 0; lane < 4; lane++) begin
         case (s.opcode)
            OP_SW:   e.byteena[3-lane] = 1'b1;
            OP_SH:   e.byteena[3-lane] = (lane / 2) == int'(off[1]);
            OP_SB:   e.byteena[3-lane] = lane == int'(off);
            OP_SWL:  e.byteena[3-lane] = lane >= int'(off);
            OP_SWR:  e.byteena[3-lane] = lane <= int'(off);
            default: e.byteena[3-lane] = 1'b0;
         endcase
      end
      return e;
   endfunction

   // Buffer occupancy and FSM hold flag follow the stage timing rules
   assign full_now   = buf_cnt == SB_CAP;
   assign push_now   = store_valid & ~full_now;
   assign take_now   = ~exp_holding | ~dmem_waitrequest;
   assign pop_now    = take_now & (buf_cnt != 0);
   assign exp_accept = exp_holding & ~dmem_waitrequest;
   assign exp_head   = exp_mem[exp_head_idx];

   always @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         exp_head_idx   <= '0;
         exp_tail_idx   <= '0;
         buf_cnt        <= 0;
         exp_holding    <= 1'b0;
         exp_restart    <= 1'b0;
         exp_restart_pc <= '0;
         exp_perf       <= '0;
         n_strobes      <= '0;
         n_writes       <= '0;
      end else begin
         if (push_now) begin
            exp_mem[exp_tail_idx] <= expected_entry(store);
            exp_tail_idx          <= exp_tail_idx + 8'd1;
         end
         if (exp_accept)
            exp_head_idx <= exp_head_idx + 8'd1;
         if (push_now && !pop_now)
            buf_cnt <= buf_cnt + 1;
         else if (pop_now && !push_now)
            buf_cnt <= buf_cnt - 1;
         if (take_now)
            exp_holding <= buf_cnt != 0;
         // Rejected store, refetch from the branch when in a delay slot
         exp_restart <= store_valid & full_now;
         if (store_valid && full_now) begin
            exp_restart_pc <= store.pc - 32'd4 * 32'(store.is_delay_slot);
            exp_perf       <= exp_perf + 32'd1;
         end
         if (store_valid)
            n_strobes <= n_strobes + 32'd1;
         if (dmem.write && !dmem_waitrequest)
            n_writes <= n_writes + 32'd1;
      end
   end

   always @(posedge clock) arst_q <= arst_n;

   function automatic void report_mismatch(input string name, input logic [31:0] expected,
                                           input logic [31:0] actual);
      check_errors++;
      $display("CHECK FAILED %s at %0t: expected %h, actual %h", name, $time, expected, actual);
   endfunction

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------
   a_reset_values: assert property (@(posedge clock)
      arst_n && !arst_q |-> !dmem.write && !restart && perf_sb_full == '0)
      else report_mismatch("reset_values", 32'd0, {dmem.write, restart, perf_sb_full[29:0]});
   a_write_strobe: assert property (@(posedge clock) disable iff (!arst_n)
      dmem.write == exp_holding)
      else report_mismatch("write_strobe", 32'(exp_holding), 32'(dmem.write));
   a_write_addr: assert property (@(posedge clock) disable iff (!arst_n)
      exp_accept |-> dmem.address == exp_head.word_addr)
      else report_mismatch("write_addr", 32'(exp_head.word_addr), 32'(dmem.address));
   a_write_data: assert property (@(posedge clock) disable iff (!arst_n)
      exp_accept |-> dmem.writedata == exp_head.data)
      else report_mismatch("write_data", exp_head.data, dmem.writedata);
   a_write_mask: assert property (@(posedge clock) disable iff (!arst_n)
      exp_accept |-> dmem.writedatamask == exp_head.byteena)
      else report_mismatch("write_mask", 32'(exp_head.byteena), 32'(dmem.writedatamask));
   a_hold_fields: assert property (@(posedge clock) disable iff (!arst_n)
      dmem.write && dmem_waitrequest |=> $stable(dmem))
      else begin
         other_errors++;
         $display("dmem request changed while waitrequest was high at %0t", $time);
      end
   a_restart: assert property (@(posedge clock) disable iff (!arst_n)
      restart == exp_restart)
      else report_mismatch("restart", 32'(exp_restart), 32'(restart));
   a_restart_pc: assert property (@(posedge clock) disable iff (!arst_n)
      restart |-> restart_pc == exp_restart_pc)
      else report_mismatch("restart_pc", exp_restart_pc, restart_pc);
   a_perf_count: assert property (@(posedge clock) disable iff (!arst_n)
      perf_sb_full == exp_perf)
      else report_mismatch("perf_sb_full", exp_perf, perf_sb_full);

   // ------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_random(output logic [31:0] value);
      rng_state = xorshift32(rng_state);
      value     = rng_state;
   endtask

   function automatic store_req_t make_store(input logic [5:0] op, input logic [31:0] addr,
                                             input logic [31:0] rt, input logic [31:0] pc,
                                             input logic ds);
      store_req_t s;
      s.opcode        = op;
      s.address       = addr;
      s.rt_val        = rt;
      s.pc            = pc;
      s.is_delay_slot = ds;
      return s;
   endfunction

   // One falling edge, waitrequest random in the mixed phase
   task automatic apply_cycle(input logic valid, input store_req_t s);
      logic [31:0] r;
      @(negedge clock);
      store       = s;
      store_valid = valid;
      if (random_wait) begin
         next_random(r);
         dmem_waitrequest = r[2:0] > 3'd2;
      end
   endtask

   // Strobe then one quiet cycle, so full hits never come back to back
   task automatic send_store(input store_req_t s);
      apply_cycle(1'b1, s);
      apply_cycle(1'b0, s);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) apply_cycle(1'b0, store);
   endtask

   task automatic send_random_store();
      logic [31:0] r_op;
      logic [31:0] r_addr;
      logic [31:0] r_data;
      logic [31:0] r_pc;
      logic [5:0]  op;
      next_random(r_op);
      next_random(r_addr);
      next_random(r_data);
      next_random(r_pc);
      case (r_op % 32'd5)
         32'd0:   op = OP_SB;
         32'd1:   op = OP_SH;
         32'd2:   op = OP_SWL;
         32'd3:   op = OP_SW;
         default: op = OP_SWR;
      endcase
      // Word and halfword stores need natural alignment
      if (op == OP_SW)
         r_addr[1:0] = 2'b00;
      else if (op == OP_SH)
         r_addr[0] = 1'b0;
      send_store(make_store(op, r_addr, r_data, {r_pc[31:2], 2'b00}, r_pc[0]));
      if (r_op[8:7] == 2'b00)
         idle_cycles(1 + int'(r_op[10:9]));
   endtask

   task automatic wait_for_drain();
      random_wait = 1'b0;
      @(negedge clock);
      dmem_waitrequest = 1'b0;
      while (buf_cnt != 0 || exp_holding)
         @(negedge clock);
   endtask

   initial begin
      int i;
      arst_n           = 1'b0;
      store_valid      = 1'b0;
      store            = '0;
      dmem_waitrequest = 1'b0;
      random_wait      = 1'b0;
      rng_state        = 32'h72af;
      check_errors     = 0;
      other_errors     = 0;
      repeat (2) @(negedge clock);
      arst_n = 1'b1;
      idle_cycles(2);

      // Every opcode at every legal offset
      send_store(make_store(OP_SW, 32'h0000_1000, 32'h1122_3344, 32'h0040_0000, 1'b0));
      for (i = 0; i < 2; i++)
         send_store(make_store(OP_SH, 32'h0000_2000 + 32'(2 * i), 32'hA1B2_C3D4,
                               32'h0040_0010, 1'b0));
      for (i = 0; i < 4; i++) begin
         send_store(make_store(OP_SB, 32'h0000_3000 + 32'(i), 32'h5566_7788,
                               32'h0040_0020, 1'b0));
         send_store(make_store(OP_SWL, 32'h0000_4000 + 32'(i), 32'h99AA_BBCC,
                               32'h0040_0030, 1'b0));
         send_store(make_store(OP_SWR, 32'h0000_5000 + 32'(i), 32'hDDEE_FF01,
                               32'h0040_0040, 1'b0));
      end
      wait_for_drain();

      // Back pressure until the buffer overflows, last one in a delay slot
      dmem_waitrequest = 1'b1;
      for (i = 0; i < 10; i++)
         send_store(make_store(OP_SW, 32'h0000_8000 + 32'(4 * i), 32'hC0DE_0000 + 32'(i),
                               32'h0040_1000 + 32'(4 * i), i == 9));
      idle_cycles(4);
      wait_for_drain();

      // Mixed run
      random_wait = 1'b1;
      for (i = 0; i < N_RANDOM; i++)
         send_random_store();
      wait_for_drain();

      @(negedge clock);
      a_store_count: assert (n_writes + perf_sb_full == n_strobes)
         else report_mismatch("store_count", n_strobes, n_writes + perf_sb_full);
      $display("Errors: %0d value mismatches, %0d other failures", check_errors, other_errors);
      if (check_errors == 0 && other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Bound of 40 cycles per store
   initial begin
      #(N_STORES * 40 * CLK_PERIOD);
      $display("Watchdog timeout: the stores did not drain in time");
      $display("Test failed");
      $finish;
   end

endmodule

//--- source/mem_store_stage.sv
`timescale 1ns/100ps

module mem_store_stage import mem_store_pkg::*; #(
   parameter int SB_BITS = 3
) (
   input  logic              clock,
   input  logic              arst_n,
   input  logic              store_valid,
   input  store_req_t        store,
   input  logic              dmem_waitrequest,
   output dmem_wr_t          dmem,
   output logic              restart,
   output logic [DATA_W-1:0] restart_pc,
   output logic [31:0]       perf_sb_full
);

   sb_entry_t          entry_in;
   sb_entry_t          head;
   logic               push;
   logic               pop;
   logic               empty;
   logic [SB_BITS-1:0] wr_ptr;
   logic [SB_BITS-1:0] rd_ptr;

   // ------------------------------------------------------------
   // Fill side
   // ------------------------------------------------------------
   store_align store_align_inst (
      .store (store),
      .entry (entry_in)
   );

   store_buffer_ctrl #(
      .SB_BITS (SB_BITS)
   ) store_buffer_ctrl_inst (
      .clock         (clock),
      .arst_n        (arst_n),
      .store_valid   (store_valid),
      .pc            (store.pc),
      .is_delay_slot (store.is_delay_slot),
      .pop           (pop),
      .push          (push),
      .wr_ptr        (wr_ptr),
      .rd_ptr        (rd_ptr),
      .empty         (empty),
      .restart       (restart),
      .restart_pc    (restart_pc),
      .perf_sb_full  (perf_sb_full)
   );

   store_buffer_ram #(
      .SB_BITS (SB_BITS)
   ) store_buffer_ram_inst (
      .clock    (clock),
      .wr_en    (push),
      .wr_ptr   (wr_ptr),
      .rd_ptr   (rd_ptr),
      .entry_in (entry_in),
      .head     (head)
   );

   // ------------------------------------------------------------
   // Drain side
   // ------------------------------------------------------------
   dmem_write_fsm dmem_write_fsm_inst (
      .clock            (clock),
      .arst_n           (arst_n),
      .empty            (empty),
      .head             (head),
      .dmem_waitrequest (dmem_waitrequest),
      .pop              (pop),
      .dmem             (dmem)
   );

   // Strobe only with a store opcode, else the entry writes no byte
   a_store_opcode: assert property (
      @(posedge clock) disable iff (!arst_n)
      store_valid |-> entry_in.byteena != '0);

endmodule

//--- source/dmem_write_fsm.sv
`timescale 1ns/100ps

module dmem_write_fsm import mem_store_pkg::*; (
   input  logic      clock,
   input  logic      arst_n,
   input  logic      empty,
   input  sb_entry_t head,
   input  logic      dmem_waitrequest,
   output logic      pop,
   output dmem_wr_t  dmem
);

   typedef enum logic {
      IDLE,
      WRITE
   } state_t;

   state_t                 state;
   logic                   take;
   logic [WORD_ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0]      data_q;
   logic [BE_W-1:0]        mask_q;

   // Free to issue when idle or the current write is accepted
   assign take = (state == IDLE) | ~dmem_waitrequest;
   assign pop  = take & ~empty;

   // ------------------------------------------------------------
   // State
   // ------------------------------------------------------------
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
      end else if (take) begin
         state <= empty ? IDLE : WRITE;
      end
   end

   // Request payload, loaded with each pop
   always_ff @(posedge clock) begin
      if (pop) begin
         addr_q <= head.word_addr;
         data_q <= head.data;
         mask_q <= head.byteena;
      end
   end

   assign dmem.address       = addr_q;
   assign dmem.write         = state == WRITE;
   assign dmem.writedata     = data_q;
   assign dmem.writedatamask = mask_q;

   // Memory sees a steady request until it takes it
   a_hold_under_wait: assert property (
      @(posedge clock) disable iff (!arst_n)
      dmem.write && dmem_waitrequest |=> $stable(dmem));

endmodule

//--- source/store_buffer_ram.sv
`timescale 1ns/100ps

module store_buffer_ram import mem_store_pkg::*; #(
   parameter int SB_BITS = 3
) (
   input  logic               clock,
   input  logic               wr_en,
   input  logic [SB_BITS-1:0] wr_ptr,
   input  logic [SB_BITS-1:0] rd_ptr,
   input  sb_entry_t          entry_in,
   output sb_entry_t          head
);

   // Data only, slots are valid by pointer position
   sb_entry_t mem [2**SB_BITS];

   always_ff @(posedge clock) begin
      if (wr_en)
         mem[wr_ptr] <= entry_in;
   end

   // Oldest entry, visible in the same cycle
   assign head = mem[rd_ptr];

endmodule

//--- source/store_buffer_ctrl.sv
`timescale 1ns/100ps

module store_buffer_ctrl import mem_store_pkg::*; #(
   parameter int SB_BITS = 3
) (
   input  logic               clock,
   input  logic               arst_n,
   input  logic               store_valid,
   input  logic [DATA_W-1:0]  pc,
   input  logic               is_delay_slot,
   input  logic               pop,
   output logic               push,
   output logic [SB_BITS-1:0] wr_ptr,
   output logic [SB_BITS-1:0] rd_ptr,
   output logic               empty,
   output logic               restart,
   output logic [DATA_W-1:0]  restart_pc,
   output logic [31:0]        perf_sb_full
);

   logic [SB_BITS-1:0] wr_ptr_inc;
   logic               full;
   logic               sb_full_hit;

   // One slot stays unused so full and empty differ
   assign wr_ptr_inc  = wr_ptr + 1'b1;
   assign full        = wr_ptr_inc == rd_ptr;
   assign empty       = wr_ptr == rd_ptr;

   assign push        = store_valid & ~full;
   assign sb_full_hit = store_valid & full;

   // ------------------------------------------------------------
   // Pointers
   // ------------------------------------------------------------
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr_inc;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Restart on full buffer
   // ------------------------------------------------------------

   // Rejected store, refetch it and count the event
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         restart      <= 1'b0;
         restart_pc   <= '0;
         perf_sb_full <= '0;
      end else begin
         restart <= sb_full_hit;
         if (sb_full_hit) begin
            // Back up to the branch when in a delay slot
            restart_pc   <= pc - (is_delay_slot ? 32'd4 : 32'd0);
            perf_sb_full <= perf_sb_full + 32'd1;
         end
      end
   end

   // Drain side must never run ahead of the fill side
   a_no_pop_empty: assert property (
      @(posedge clock) disable iff (!arst_n) pop |-> !empty);

   // Pipeline flushes behind a restart, so full hits never come back to back
   a_restart_one_cycle: assert property (
      @(posedge clock) disable iff (!arst_n) restart |=> !restart);

endmodule

//--- source/store_align.sv
`timescale 1ns/100ps

module store_align import mem_store_pkg::*; (
   input  store_req_t store,
   output sb_entry_t  entry
);

   logic [1:0]        rot_delta;
   logic [1:0]        rot;
   logic [DATA_W-1:0] rt;
   logic [BE_W-1:0]   byteena;
   logic [DATA_W-1:0] data;

   assign rt = store.rt_val;

   // ------------------------------------------------------------
   // Lane rotation
   // ------------------------------------------------------------

   // Per-opcode offset added to the address low bits
   always_comb begin
      case (store.opcode)
         OP_SW:   rot_delta = 2'd0;
         OP_SWL:  rot_delta = 2'd0;
         OP_SH:   rot_delta = 2'd2;
         OP_SB:   rot_delta = 2'd1;
         OP_SWR:  rot_delta = 2'd1;
         default: rot_delta = 2'd0;
      endcase
   end

   // Two-bit sum wraps, so the rotation stays within one word
   assign rot = store.address[1:0] + rot_delta;

   // Rotate right by whole bytes
   always_comb begin
      case (rot)
         2'd0:    data = rt;
         2'd1:    data = {rt[7:0], rt[31:8]};
         2'd2:    data = {rt[15:0], rt[31:16]};
         default: data = {rt[23:0], rt[31:24]};
      endcase
   end

   // ------------------------------------------------------------
   // Byte enables, big endian
   // ------------------------------------------------------------
   always_comb begin
      case (store.opcode)
         OP_SW:   byteena = 4'hF;
         // Upper half at offset 0, lower half at offset 2
         OP_SH:   byteena = store.address[1] ? 4'h3 : 4'hC;
         OP_SB:   byteena = 4'h8 >> store.address[1:0];
         // Addressed byte down to the LSB
         OP_SWL:  byteena = 4'hF >> store.address[1:0];
         // MSB down to the addressed byte
         OP_SWR:  byteena = 4'hF << ~store.address[1:0];
         // Not a store, nothing to write
         default: byteena = 4'h0;
      endcase
   end

   assign entry.word_addr = store.address[DATA_W-1:2];
   assign entry.data      = data;
   assign entry.byteena   = byteena;

endmodule

//--- source/mem_store_pkg.sv
package mem_store_pkg;

   // ------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------
   localparam int DATA_W      = 32;
   localparam int WORD_ADDR_W = 30;
   localparam int BE_W        = 4;
   localparam int OPCODE_W    = 6;

   // MIPS store opcodes
   localparam logic [OPCODE_W-1:0] OP_SB  = 6'h28;
   localparam logic [OPCODE_W-1:0] OP_SH  = 6'h29;
   localparam logic [OPCODE_W-1:0] OP_SWL = 6'h2A;
   localparam logic [OPCODE_W-1:0] OP_SW  = 6'h2B;
   localparam logic [OPCODE_W-1:0] OP_SWR = 6'h2E;

   // ------------------------------------------------------------
   // Payloads
   // ------------------------------------------------------------

   // One store from the execute stage, qualified by store_valid
   typedef struct packed {
      logic [OPCODE_W-1:0] opcode;
      logic [DATA_W-1:0]   address;      // Byte address
      logic [DATA_W-1:0]   rt_val;       // Register value, unaligned
      logic [DATA_W-1:0]   pc;
      logic                is_delay_slot;
   } store_req_t;

   // One slot of the store buffer
   typedef struct packed {
      logic [WORD_ADDR_W-1:0] word_addr;
      logic [DATA_W-1:0]      data;      // Already in big-endian lanes
      logic [BE_W-1:0]        byteena;   // Bit 3 is lane 0, the MSB
   } sb_entry_t;

   // Write request towards main memory
   typedef struct packed {
      logic [WORD_ADDR_W-1:0] address;
      logic                   write;
      logic [DATA_W-1:0]      writedata;
      logic [BE_W-1:0]        writedatamask;
   } dmem_wr_t;

endpackage
